// ==== source/scroll_pkg.sv ====
// sizes and shared decode for the scroll layer
// all widths are fixed by the board, nothing here is meant to be tuned
package scroll_pkg;

    localparam int map_aw = 10;  // 32x32 tiles, 1024 entries
    localparam int rom_aw = 17;  // gfx rom word address
    localparam int rom_dw = 16;  // four planar 4bpp pixels per word
    localparam int pxl_w  = 8;   // palette + color index

    // one tile map entry, seen byte-wise by the cpu and field-wise by the renderer
    typedef union packed {
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } cpu;
        struct packed {
            logic       prio_bit;  // top palette bit, used for priority
            logic       flip;      // horizontal mirror
            logic [2:0] pal;
            logic [2:0] code_hi;
            logic [7:0] code_lo;
        } gfx;
    } tile_attr_t;

    // planar rom word to packed nibbles, pixel 0 in the low nibble
    function automatic logic [rom_dw-1:0] planar_to_packed(input logic [rom_dw-1:0] w);
        logic [rom_dw-1:0] px;
        px = '0;
        for (int n = 0; n < 4; n++) begin
            px[4*n +: 4] = {w[n+12], w[n+8], w[n+4], w[n]};  // plane 3 is the msb
        end
        return px;
    endfunction

endpackage

// ==== source/scroll_ifs.sv ====
`timescale 1ns/1ps
// internal links of the scroll pipeline
// map_if carries the scrolled position and the tile map entry
// pix_if carries the per-group load strobe and tile attributes

interface map_if;
    import scroll_pkg::*;

    logic [8:0]        hscr;       // HPOS + scrhpos, with carry
    logic [8:0]        vscr;       // VPOS + scrvpos, with carry
    logic              phase0;     // first pixel of a four-pixel group
    logic [map_aw-1:0] scan_addr;  // renderer address into the tile map
    tile_attr_t        attr;       // registered map word

    modport pos   (output hscr, output vscr, output phase0, output scan_addr);
    modport map   (input scan_addr, output attr);
    modport fetch (input hscr, input vscr, input phase0, input attr);
endinterface

interface pix_if;
    logic       load;   // pxl_cen wide pulse at phase 0
    logic [3:0] pal4;   // prio bit + palette
    logic       hflip;

    modport fetch (output load, output pal4, output hflip);
    modport shift (input load, input pal4, input hflip);
endinterface

// ==== source/scroll_pos.sv ====
`timescale 1ns/1ps
// scrolled raster position, registered on pxl_cen
// one strobe of latency from HPOS/VPOS to hscr/vscr
// sums wrap at 9 bits, no clamping
module scroll_pos (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic [7:0] HPOS,
    input  logic [7:0] VPOS,
    input  logic [7:0] scrhpos,
    input  logic [7:0] scrvpos,
    map_if.pos         m
);

    logic [8:0] hsum;  // carry kept
    logic [8:0] vsum;

    assign hsum = {1'b0, HPOS} + {1'b0, scrhpos};
    assign vsum = {1'b0, VPOS} + {1'b0, scrvpos};

    always_ff @(posedge clk) begin
        if (rst) begin
            m.hscr   <= '0;
            m.vscr   <= '0;
            m.phase0 <= 1'b0;
        end else if (pxl_cen) begin
            m.hscr   <= hsum;  // bit 8 latched like the board does
            m.vscr   <= vsum;
            m.phase0 <= (HPOS[1:0] == 2'd0);  // group boundary
        end
    end

    // 16x16 tile under the scrolled pixel
    // vscr[8] and hscr[7] pick the map quadrant
    assign m.scan_addr = {m.vscr[8], m.hscr[7], m.vscr[7:4], m.hscr[7:4]};

endmodule

// ==== source/scroll_map_ram.sv ====
`timescale 1ns/1ps
// tile map, two 1024x8 byte arrays sharing one address
// cpu wins the address while scr_cs is high, renderer sees stale data then
// reads are registered on every clk, writes need cen_E
// cpu must hold cpu_AB and scr_cs for two clks on a read
module scroll_map_ram (
    input  logic                    clk,
    input  logic                    cen_E,
    input  logic                    scr_cs,
    input  logic                    cpu_wrn,
    input  logic [scroll_pkg::map_aw:0] cpu_AB,   // word addr + byte select
    input  logic [7:0]              cpu_dout,
    output logic [7:0]              scr_dout,
    map_if.map                      m
);
    import scroll_pkg::*;

    logic [7:0]        mem_hi [0:(1<<map_aw)-1];  // attribute byte
    logic [7:0]        mem_lo [0:(1<<map_aw)-1];  // code low byte
    logic [map_aw-1:0] ram_addr;
    logic              cpu_we;
    logic              hi_we;
    logic              lo_we;
    tile_attr_t        rd_word;

    assign ram_addr = scr_cs ? cpu_AB[map_aw:1] : m.scan_addr;  // cpu priority

    assign cpu_we = scr_cs && !cpu_wrn && cen_E;
    assign hi_we  = cpu_we &&  cpu_AB[0];  // odd byte
    assign lo_we  = cpu_we && !cpu_AB[0];

    always_ff @(posedge clk) begin
        if (hi_we) begin
            mem_hi[ram_addr] <= cpu_dout;
        end
        if (lo_we) begin
            mem_lo[ram_addr] <= cpu_dout;
        end
        rd_word.cpu.hi <= mem_hi[ram_addr];  // old data on a write cycle
        rd_word.cpu.lo <= mem_lo[ram_addr];
    end

    // same word feeds both views
    assign m.attr = rd_word;

    // byte select follows the held cpu address
    assign scr_dout = cpu_AB[0] ? rd_word.cpu.hi : rd_word.cpu.lo;

endmodule

// ==== source/tile_fetch.sv ====
`timescale 1ns/1ps
// tile decode and rom request, once per four-pixel group
// rom_addr holds for four strobes, the rom must answer in that window
// attr is read one clk after the scan address, so pxl_cen must not
// run on consecutive clks
module tile_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    map_if.fetch                        m,
    pix_if.fetch                        p,
    output logic [scroll_pkg::rom_aw-1:0] rom_addr
);

    logic        fetch;     // group boundary strobe
    logic [10:0] code;      // 2048 tiles
    logic [1:0]  col_sel;   // 4-pixel column inside the tile
    logic [3:0]  row_sel;   // line inside the tile

    assign fetch = pxl_cen && m.phase0;
    assign p.load = fetch;  // shifter takes the previous rom word now

    assign code    = {m.attr.gfx.code_hi, m.attr.gfx.code_lo};
    assign col_sel = m.hscr[3:2] ^ {2{m.attr.gfx.flip}};  // mirrored column order
    assign row_sel = m.vscr[3:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_addr <= '0;
            p.pal4   <= '0;
            p.hflip  <= 1'b0;
        end else if (fetch) begin
            rom_addr <= {code, col_sel, row_sel};
            // palette and flip travel one group behind the address
            p.pal4   <= {m.attr.gfx.prio_bit, m.attr.gfx.pal};  // bit 3 is priority
            p.hflip  <= m.attr.gfx.flip;
        end
    end

endmodule

// ==== source/pixel_shifter.sv ====
`timescale 1ns/1ps
// rom word to pixel stream, four pixels per load
// rom_ok low at load gives a group of color 0 with the palette kept
// no back-pressure, a late rom is simply dropped
module pixel_shifter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    pix_if.shift                        p,
    input  logic [scroll_pkg::rom_dw-1:0] rom_data,
    input  logic                        rom_ok,
    output logic [scroll_pkg::pxl_w-1:0]  scr_pxl
);
    import scroll_pkg::*;

    logic [rom_dw-1:0] pk_word;   // packed nibbles of the incoming word
    logic [rom_dw-1:0] shift;     // pixels still to show
    logic [3:0]        pal_q;     // palette of the group on screen
    logic              hflip_q;
    logic [3:0]        first_px;
    logic [3:0]        next_px;

    assign pk_word = rom_ok ? planar_to_packed(rom_data) : '0;  // missing data is blank

    // flipped tiles start from the high nibble
    assign first_px = p.hflip ? pk_word[rom_dw-1 -: 4] : pk_word[3:0];
    assign next_px  = hflip_q ? shift[rom_dw-1 -: 4] : shift[3:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            shift   <= '0;
            pal_q   <= '0;
            hflip_q <= 1'b0;
            scr_pxl <= '0;
        end else if (pxl_cen) begin
            if (p.load) begin
                // pal4/hflip still hold the previous group, matching rom_data
                scr_pxl <= {p.pal4, first_px};
                shift   <= p.hflip ? (pk_word << 4) : (pk_word >> 4);
                pal_q   <= p.pal4;
                hflip_q <= p.hflip;
            end else begin
                scr_pxl <= {pal_q, next_px};
                shift   <= hflip_q ? (shift << 4) : (shift >> 4);  // left when mirrored
            end
        end
    end

endmodule

// ==== source/scroll_layer.sv ====
`timescale 1ns/1ps
// background scroll layer, tile map lookup to colored pixels
// pixels for a group appear four pxl_cen after its phase-0 strobe
// rom must answer within four pixel strobes, no screen flip support
module scroll_layer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic                          cen_E,
    // cpu side
    input  logic [scroll_pkg::map_aw:0]   cpu_AB,
    input  logic                          scr_cs,
    input  logic                          cpu_wrn,
    input  logic [7:0]                    cpu_dout,
    output logic [7:0]                    scr_dout,
    // raster and scroll registers
    input  logic [7:0]                    HPOS,
    input  logic [7:0]                    VPOS,
    input  logic [7:0]                    scrhpos,
    input  logic [7:0]                    scrvpos,
    // gfx rom
    output logic [scroll_pkg::rom_aw-1:0] rom_addr,
    input  logic [scroll_pkg::rom_dw-1:0] rom_data,
    input  logic                          rom_ok,
    output logic [scroll_pkg::pxl_w-1:0]  scr_pxl
);

    map_if m_if ();  // position and map word
    pix_if p_if ();  // load strobe and attributes

    scroll_pos u_pos (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .HPOS    (HPOS),
        .VPOS    (VPOS),
        .scrhpos (scrhpos),
        .scrvpos (scrvpos),
        .m       (m_if.pos)
    );

    scroll_map_ram u_map (
        .clk      (clk),
        .cen_E    (cen_E),
        .scr_cs   (scr_cs),
        .cpu_wrn  (cpu_wrn),
        .cpu_AB   (cpu_AB),
        .cpu_dout (cpu_dout),
        .scr_dout (scr_dout),
        .m        (m_if.map)
    );

    tile_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .m        (m_if.fetch),
        .p        (p_if.fetch),
        .rom_addr (rom_addr)
    );

    pixel_shifter u_shift (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .p        (p_if.shift),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .scr_pxl  (scr_pxl)
    );

endmodule

// ==== test/scroll_layer_asserts.sv ====
`timescale 1ns/1ps
// bound checks on the scroll layer ports
// expected values come from the testbench map shadow and the raster inputs
// pixel checks count clks, so pxl_cen must run on every second clk
// the map must not be written while pixels are checked
module scroll_layer_asserts (
    input logic                          clk,
    input logic                          rst,
    input logic                          pxl_cen,
    input logic [scroll_pkg::map_aw:0]   cpu_AB,
    input logic                          scr_cs,
    input logic                          cpu_wrn,
    input logic [7:0]                    scr_dout,
    input logic [7:0]                    HPOS,
    input logic [7:0]                    VPOS,
    input logic [7:0]                    scrhpos,
    input logic [7:0]                    scrvpos,
    input logic [scroll_pkg::rom_aw-1:0] rom_addr,
    input logic [scroll_pkg::rom_dw-1:0] rom_data,
    input logic                          rom_ok,
    input logic [scroll_pkg::pxl_w-1:0]  scr_pxl
);
    import scroll_pkg::*;

    logic [8:0]        hs;          // scrolled column
    logic [8:0]        vs;          // scrolled line
    logic [map_aw-1:0] scan;        // tile under the scrolled pixel
    tile_attr_t        ent;         // shadow entry at scan
    logic [15:0]       cpu_word;    // shadow entry at the cpu address
    logic [7:0]        rd_exp;
    logic [rom_aw-1:0] exp_addr;
    logic [3:0]        exp_pal;
    logic              exp_flip;
    logic              p0_strobe;   // first strobe of a group

    assign hs        = {1'b0, HPOS} + {1'b0, scrhpos};
    assign vs        = {1'b0, VPOS} + {1'b0, scrvpos};
    assign scan      = {vs[8], hs[7], vs[7:4], hs[7:4]};
    assign ent       = scroll_layer_tb.shadow[scan];
    assign cpu_word  = scroll_layer_tb.shadow[cpu_AB[map_aw:1]];
    assign rd_exp    = cpu_AB[0] ? cpu_word[15:8] : cpu_word[7:0];  // odd byte is hi
    assign exp_flip  = ent.gfx.flip;
    assign exp_pal   = {ent.gfx.prio_bit, ent.gfx.pal};
    assign exp_addr  = {ent.gfx.code_hi, ent.gfx.code_lo, hs[3:2] ^ {2{exp_flip}}, vs[3:0]};
    assign p0_strobe = pxl_cen && (HPOS[1:0] == 2'd0);

    // planar pick of pixel n where mirrored tiles count from the top
    function automatic logic [3:0] exp_nibble(input logic [15:0] w, input logic ok,
                                              input logic flip, input int n);
        int idx;
        idx = flip ? 3 - n : n;
        // missing rom word is color 0
        return ok ? {w[idx+12], w[idx+8], w[idx+4], w[idx]} : 4'd0;  // plane 3 is the msb
    endfunction

    // map read-back one clk after the held address
    assert property (@(posedge clk) disable iff (rst)
        (scr_cs && cpu_wrn && $past(scr_cs && cpu_wrn) && cpu_AB == $past(cpu_AB))
            |-> scr_dout == rd_exp)
    else begin
        $error("Mismatch at %0t: scr_dout %h, expected %h", $time, scr_dout, rd_exp);
        scroll_layer_tb.assert_fail = 1'b1;
    end

    // rom request one strobe after the phase-0 strobe
    assert property (@(posedge clk) disable iff (rst)
        $past(p0_strobe, 3) |-> rom_addr == $past(exp_addr, 3))
    else begin
        $error("Mismatch at %0t: rom_addr %h, expected %h", $time, rom_addr,
               $past(exp_addr, 3));
        scroll_layer_tb.assert_fail = 1'b1;
    end

    // pixels of a group loaded four strobes after its fetch
    for (genvar n = 0; n < 4; n++) begin : g_pixel
        localparam int d_grp  = 12 + 2 * n;  // back to the phase-0 strobe
        localparam int d_load = 2 + 2 * n;   // back to the load strobe
        assert property (@(posedge clk) disable iff (rst)
            $past(p0_strobe, d_grp) |->
                scr_pxl == {$past(exp_pal, d_grp),
                            exp_nibble($past(rom_data, d_load), $past(rom_ok, d_load),
                                       $past(exp_flip, d_grp), n)})
        else begin
            $error("Mismatch at %0t: scr_pxl %h wrong for pixel %0d of group",
                   $time, scr_pxl, n);
            scroll_layer_tb.assert_fail = 1'b1;
        end
    end

    // outputs cleared by reset and still clear one clk later
    assert property (@(posedge clk)
        $past(rst) |-> (rom_addr == '0 && scr_pxl == '0))
    else begin
        $error("Mismatch at %0t: rom_addr %h scr_pxl %h after reset", $time,
               rom_addr, scr_pxl);
        scroll_layer_tb.assert_fail = 1'b1;
    end

endmodule

// ==== test/scroll_layer_tb.sv ====
`timescale 1ns/1ps
// testbench for the scroll layer, checking is done by the bound asserts
// cpu fills the whole map first, then pixels run with the map left alone
// rom is modelled here and answers on the falling edge after rom_addr moves
module scroll_layer_tb;
    import scroll_pkg::*;

    localparam logic [31:0] seed = 32'he8a19b4d;
    localparam int fill_clks     = 2 * 1024 + 1;   // both bytes plus the blocked write
    localparam int read_clks     = 3 * 16;
    localparam int pixel_strobes = 4096;           // 16 lines
    localparam int max_cycles    = 2 * (fill_clks + read_clks + 2 * pixel_strobes);

    logic              clk = 1'b0;
    logic              rst;
    logic              pxl_cen;
    logic              cen_E;
    logic [map_aw:0]   cpu_AB;
    logic              scr_cs;
    logic              cpu_wrn;
    logic [7:0]        cpu_dout;
    logic [7:0]        scr_dout;
    logic [7:0]        HPOS;
    logic [7:0]        VPOS;
    logic [7:0]        scrhpos;
    logic [7:0]        scrvpos;
    logic [rom_aw-1:0] rom_addr;
    logic [rom_dw-1:0] rom_data = '0;
    logic              rom_ok;
    logic [pxl_w-1:0]  scr_pxl;

    logic [15:0] shadow [0:(1<<map_aw)-1];  // map contents as the cpu wrote them
    logic [31:0] lfsr;
    bit          assert_fail;              // set by the bound asserts
    int          cycle_cnt;

    scroll_layer i_scroll_layer (.*);

    bind scroll_layer scroll_layer_asserts u_asserts (
        .clk (clk), .rst (rst), .pxl_cen (pxl_cen), .cpu_AB (cpu_AB),
        .scr_cs (scr_cs), .cpu_wrn (cpu_wrn), .scr_dout (scr_dout),
        .HPOS (HPOS), .VPOS (VPOS), .scrhpos (scrhpos), .scrvpos (scrvpos),
        .rom_addr (rom_addr), .rom_data (rom_data), .rom_ok (rom_ok),
        .scr_pxl (scr_pxl)
    );

    always #50 clk = ~clk;  // 100 ns

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // taps 32 22 2 1
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    // gfx rom contents, address times a constant with the top half folded down
    function automatic logic [15:0] rom_word(input logic [rom_aw-1:0] a);
        logic [31:0] prod;
        prod = {15'd0, a} * 32'h0000_9e37;
        return prod[15:0] ^ prod[31:16];
    endfunction

    always @(negedge clk) rom_data <= rom_word(rom_addr);

    task automatic cpu_write(input logic [map_aw:0] ab, input logic [7:0] d, input logic en);
        @(negedge clk);
        scr_cs   = 1'b1;
        cpu_wrn  = 1'b0;
        cen_E    = en;
        cpu_AB   = ab;
        cpu_dout = d;
        @(posedge clk);
        if (en && ab[0]) begin
            shadow[ab[map_aw:1]][15:8] = d;
        end else if (en) begin
            shadow[ab[map_aw:1]][7:0] = d;
        end
    endtask

    task automatic cpu_read(input logic [map_aw:0] ab);
        @(negedge clk);
        scr_cs  = 1'b1;
        cpu_wrn = 1'b1;
        cen_E   = 1'b0;
        cpu_AB  = ab;
        repeat (2) @(posedge clk);  // address held for two clks
    endtask

    task automatic cpu_idle();
        @(negedge clk);
        scr_cs  = 1'b0;
        cpu_wrn = 1'b1;
        cen_E   = 1'b0;
    endtask

    task automatic new_line();
        logic [31:0] r;
        rand_bits(8, r);
        VPOS = r[7:0];
        rand_bits(8, r);
        scrhpos = r[7:0];
        rand_bits(8, r);
        scrvpos = r[7:0];
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, no result after %0d clock cycles", cycle_cnt);
        $display("Simulation failed");
        $fatal(1, "run stopped by the cycle limit");
    end

    initial begin : fail_watch
        wait (assert_fail);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first assertion failure");
    end

    initial begin : stimulus
        logic [31:0] r;
        lfsr     = seed;
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        cen_E    = 1'b0;
        cpu_AB   = '0;
        scr_cs   = 1'b0;
        cpu_wrn  = 1'b1;
        cpu_dout = '0;
        HPOS     = '0;
        VPOS     = '0;
        scrhpos  = '0;
        scrvpos  = '0;
        rom_ok   = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int a = 0; a < 2048; a++) begin  // whole map, lo then hi byte
            rand_bits(8, r);
            cpu_write(a[map_aw:0], r[7:0], 1'b1);
        end
        cpu_write(11'h00b, ~shadow[5][15:8], 1'b0);  // no cen_E, must not land
        cpu_read(11'h00b);
        cpu_read(11'h00a);
        for (int i = 0; i < 14; i++) begin
            rand_bits(11, r);
            cpu_read(r[map_aw:0]);
        end
        cpu_idle();

        new_line();
        for (int pc = 0; pc < pixel_strobes; pc++) begin
            @(negedge clk);
            pxl_cen = 1'b1;
            rom_ok  = !(pc >= 1000 && pc < 1004);  // one load sees no rom data
            @(negedge clk);
            pxl_cen = 1'b0;
            if (HPOS == 8'd255) begin
                HPOS = 8'd0;
                new_line();
            end else begin
                HPOS = HPOS + 8'd1;
            end
        end

        if (assert_fail) begin
            $display("Simulation failed");
            $fatal(1, "assertion failure seen at the end of the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== list.f ====
source/scroll_pkg.sv
source/scroll_ifs.sv
source/scroll_pos.sv
source/scroll_map_ram.sv
source/tile_fetch.sv
source/pixel_shifter.sv
source/scroll_layer.sv
test/scroll_layer_asserts.sv
test/scroll_layer_tb.sv

// ==== Makefile ====
# Verilator flow for the scroll layer
# make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= scroll_layer_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "sim: PASS"; \
	else \
		echo "sim: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
